// File: logic/controlPkg.sv
// ----------------------------------------
// control package
// shared widths, state and class enums and the
// control bundles of the multicycle control unit
// ----------------------------------------

package controlPkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------

	localparam int maxLanes = 8;	// widest vector supported

	typedef logic [7:0] instrT;	// instruction register byte
	typedef logic [maxLanes-1:0] laneMaskT;	// one load strobe per lane
	typedef logic [2:0] laneIndexT;	// current lane, also the memory offset

	// operand B selector
	typedef logic [2:0] aluSrcBT;

	localparam aluSrcBT aluSrcReg = 3'd0;
	localparam aluSrcBT aluSrcOne = 3'd1;	// pc increment
	localparam aluSrcBT aluSrcOffset = 3'd2;	// branch offset
	localparam aluSrcBT aluSrcOriImm = 3'd3;
	localparam aluSrcBT aluSrcShift = 3'd4;	// shift amount

	// ----------------------------------------
	// enums
	// ----------------------------------------

	typedef enum logic [2:0]
	{
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluOr = 3'd2,
		aluNand = 3'd3,
		aluShift = 3'd4
	} aluOpT;

	typedef enum logic [3:0]
	{
		classAsn, classShift, classOri, classLoad, classStore,
		classBpz, classBz, classBnz, classVload, classVstore,
		classNop, classStop, classIllegal
	} instrClassT;

	// 18 states, so five bits
	typedef enum logic [4:0]
	{
		stIdle, stFetch, stDecode, stArith, stWriteBack, stShift,
		stOriRead, stOriAlu, stOriWrite, stLoadRead, stLoadWrite,
		stStore, stBranch, stNop, stHalt,
		stVloadLane, stVloadWrite, stVstoreLane
	} stateT;

	// ----------------------------------------
	// control bundles
	// ----------------------------------------

	typedef struct packed
	{
		logic pcWrite;
		logic addrSel;	// pc drives the memory address
		logic memRead;
		logic memWrite;
		logic irLoad;
		logic mdrLoad;
	} fetchCtrlT;

	typedef struct packed
	{
		logic r1Sel;
		logic regLoad;	// load both register operands
		logic aluSrcA;
		aluSrcBT aluSrcB;
		aluOpT aluOp;
		logic aluOutWrite;
		logic regFileWrite;
		logic regIn;	// write back from mdr
		logic flagWrite;
	} aluCtrlT;

	typedef struct packed
	{
		logic r2Load;
		logic r2Sel;	// r2 takes the incremented address
		logic voutSel;
		logic vectorWrite;
		laneMaskT laneLoad;
		laneIndexT laneSel;
	} vectorCtrlT;

endpackage

// File: logic/opcodeDecoder.sv
// ----------------------------------------
// opcode decoder
// sorts the held instruction byte into a class
// ----------------------------------------

`timescale 1ns/1ps

module opcodeDecoder
(
	input controlPkg::instrT instr,
	output controlPkg::instrClassT instrClass
);

	import controlPkg::*;

	logic [3:0] lowNibble;
	logic [2:0] lowBits;

	assign lowNibble = instr[3:0];
	assign lowBits = instr[2:0];

	// priority order matters, shift and ori only look at three bits
	always_comb
	begin
		if (lowNibble == 4'h4 || lowNibble == 4'h6 || lowNibble == 4'h8)
			instrClass = classAsn;
		else if (lowBits == 3'd3)
			instrClass = classShift;
		else if (lowBits == 3'd7)
			instrClass = classOri;
		else
		begin
			case (lowNibble)
				4'h0: instrClass = classLoad;
				4'h2: instrClass = classStore;
				4'hd: instrClass = classBpz;
				4'h5: instrClass = classBz;
				4'h9: instrClass = classBnz;
				4'ha: instrClass = classVload;
				4'hc: instrClass = classVstore;
				default:
				begin
					if (instr == 8'h81)
						instrClass = classNop;
					else if (instr == 8'h01)
						instrClass = classStop;
					else
						instrClass = classIllegal;	// includes the old vadd code
				end
			endcase
		end
	end

	// a known byte always lands in some class
	always_comb
	begin
		if (!$isunknown(instr))
			assert (!$isunknown(instrClass))
				else $error("opcodeDecoder: unknown class for instr %h", instr);
	end

endmodule

// File: logic/controlSequencer.sv
// ----------------------------------------
// control sequencer
// state register, lane counter and next-state logic
// ----------------------------------------

`timescale 1ns/1ps

module controlSequencer
#(
	parameter int numLanes = 4
)
(
	input logic clock,
	input logic reset,
	input controlPkg::instrClassT instrClass,
	output controlPkg::stateT state,
	output controlPkg::laneIndexT laneIndex
);

	import controlPkg::*;

	stateT nextState;
	logic lastLane;
	logic laneState;

	initial
	begin
		assert (numLanes >= 1 && numLanes <= maxLanes)
			else $error("controlSequencer: numLanes %0d out of range", numLanes);
	end

	assign lastLane = (laneIndex == laneIndexT'(numLanes - 1));
	assign laneState = (state == stVloadLane) || (state == stVstoreLane);

	// ----------------------------------------
	// state register
	// ----------------------------------------

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= stIdle;
		else
			state <= nextState;
	end

	// lane counter, holds on the last lane
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			laneIndex <= '0;
		else if (state == stDecode)
			laneIndex <= '0;
		else if (laneState && !lastLane)
			laneIndex <= laneIndex + laneIndexT'(1);
	end

	// ----------------------------------------
	// next state
	// ----------------------------------------

	always_comb
	begin
		nextState = stIdle;
		case (state)
			stIdle: nextState = stFetch;
			stFetch: nextState = stDecode;
			stDecode:
			begin
				case (instrClass)
					classAsn: nextState = stArith;
					classShift: nextState = stShift;
					classOri: nextState = stOriRead;
					classLoad: nextState = stLoadRead;
					classStore: nextState = stStore;
					classBpz, classBz, classBnz: nextState = stBranch;
					classVload: nextState = stVloadLane;
					classVstore: nextState = stVstoreLane;
					classNop: nextState = stNop;
					classStop: nextState = stHalt;
					default: nextState = stIdle;	// illegal burns one idle cycle
				endcase
			end
			stArith, stShift: nextState = stWriteBack;
			stOriRead: nextState = stOriAlu;
			stOriAlu: nextState = stOriWrite;
			stLoadRead: nextState = stLoadWrite;
			stWriteBack, stOriWrite, stLoadWrite: nextState = stFetch;
			stStore, stBranch, stNop: nextState = stFetch;
			stHalt: nextState = stHalt;	// only reset gets out
			stVloadLane: nextState = lastLane ? stVloadWrite : stVloadLane;
			stVloadWrite: nextState = stFetch;
			stVstoreLane: nextState = lastLane ? stFetch : stVstoreLane;
			default: nextState = stIdle;
		endcase
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// counter never runs past the configured lanes
	laneInRange: assert property (
		@(posedge clock) disable iff (reset)
		int'(laneIndex) < numLanes
	) else $error("controlSequencer: laneIndex %0d beyond numLanes", laneIndex);

	haltIsFinal: assert property (
		@(posedge clock) disable iff (reset)
		state == stHalt |=> state == stHalt
	) else $error("controlSequencer: left stHalt without reset");

endmodule

// File: logic/controlOutputs.sv
// ----------------------------------------
// control output table
// builds the fetch, alu and vector bundles from state
// ----------------------------------------

`timescale 1ns/1ps

module controlOutputs
#(
	parameter int numLanes = 4
)
(
	input controlPkg::stateT state,
	input controlPkg::instrClassT instrClass,
	input controlPkg::instrT instr,
	input controlPkg::laneIndexT laneIndex,
	input logic negative,
	input logic zero,
	output controlPkg::fetchCtrlT fetchCtrl,
	output controlPkg::aluCtrlT aluCtrl,
	output controlPkg::vectorCtrlT vectorCtrl,
	output logic stop
);

	import controlPkg::*;

	laneMaskT laneEnable;
	laneMaskT laneOneHot;
	aluOpT asnOp;
	logic branchTaken;

	assign laneEnable = laneMaskT'((1 << numLanes) - 1);
	assign laneOneHot = (laneMaskT'(1) << laneIndex) & laneEnable;

	// add, sub and nand share one class, bits 2:1 tell them apart
	always_comb
	begin
		case (instr[2:1])
			2'b10: asnOp = aluAdd;
			2'b11: asnOp = aluSub;
			default: asnOp = aluNand;
		endcase
	end

	always_comb
	begin
		case (instrClass)
			classBpz: branchTaken = !negative;
			classBz: branchTaken = zero;
			classBnz: branchTaken = !zero;
			default: branchTaken = 1'b0;
		endcase
	end

	// ----------------------------------------
	// per-state table, zero unless named
	// ----------------------------------------

	always_comb
	begin
		fetchCtrl = '0;
		aluCtrl = '0;
		vectorCtrl = '0;
		stop = 1'b0;
		case (state)
			stFetch:
			begin
				fetchCtrl.pcWrite = 1'b1;
				fetchCtrl.addrSel = 1'b1;
				fetchCtrl.memRead = 1'b1;
				fetchCtrl.irLoad = 1'b1;
				aluCtrl.aluSrcB = aluSrcOne;	// pc + 1
			end
			stDecode:
			begin
				aluCtrl.regLoad = 1'b1;
				vectorCtrl.r2Load = 1'b1;
			end
			stArith:
			begin
				aluCtrl.aluSrcA = 1'b1;
				aluCtrl.aluOp = asnOp;
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.flagWrite = 1'b1;
			end
			stShift:
			begin
				aluCtrl.aluSrcA = 1'b1;
				aluCtrl.aluSrcB = aluSrcShift;
				aluCtrl.aluOp = aluShift;
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.flagWrite = 1'b1;
			end
			stWriteBack: aluCtrl.regFileWrite = 1'b1;
			stOriRead:
			begin
				aluCtrl.r1Sel = 1'b1;	// ori works on k1
				aluCtrl.regLoad = 1'b1;
			end
			stOriAlu:
			begin
				aluCtrl.aluSrcA = 1'b1;
				aluCtrl.aluSrcB = aluSrcOriImm;
				aluCtrl.aluOp = aluOr;
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.flagWrite = 1'b1;
			end
			stOriWrite:
			begin
				aluCtrl.r1Sel = 1'b1;
				aluCtrl.regFileWrite = 1'b1;
			end
			stLoadRead:
			begin
				fetchCtrl.memRead = 1'b1;
				fetchCtrl.mdrLoad = 1'b1;
			end
			stLoadWrite:
			begin
				aluCtrl.aluOutWrite = 1'b1;
				aluCtrl.regFileWrite = 1'b1;
				aluCtrl.regIn = 1'b1;
			end
			stStore: fetchCtrl.memWrite = 1'b1;
			stBranch:
			begin
				fetchCtrl.pcWrite = branchTaken;
				aluCtrl.aluSrcB = aluSrcOffset;
			end
			stHalt: stop = 1'b1;
			stVloadLane:
			begin
				fetchCtrl.memRead = 1'b1;
				vectorCtrl.r2Sel = 1'b1;
				vectorCtrl.r2Load = 1'b1;	// step the address
				vectorCtrl.voutSel = 1'b1;
				vectorCtrl.laneSel = laneIndex;
				vectorCtrl.laneLoad = laneOneHot;
			end
			stVloadWrite:
			begin
				vectorCtrl.vectorWrite = 1'b1;
				vectorCtrl.r2Sel = 1'b1;
			end
			stVstoreLane:
			begin
				fetchCtrl.memWrite = 1'b1;
				vectorCtrl.r2Load = 1'b1;
				vectorCtrl.laneSel = laneIndex;
				vectorCtrl.r2Sel = (laneIndex != '0);	// lane 0 uses the base address
			end
			default:
			begin
				stop = 1'b0;	// idle and nop drive nothing
			end
		endcase
	end

	// memory port is single, never read and write at once
	always_comb
	begin
		assert (!(fetchCtrl.memRead && fetchCtrl.memWrite))
			else $error("controlOutputs: memRead and memWrite both high in %s", state.name());
	end

endmodule

// File: logic/controlUnit.sv
// ----------------------------------------
// multicycle control unit
// decoder, sequencer and output table
// ----------------------------------------

`timescale 1ns/1ps

module controlUnit
#(
	parameter int numLanes = 4
)
(
	input logic clock,
	input logic reset,
	input controlPkg::instrT instr,
	input logic negative,
	input logic zero,
	output controlPkg::fetchCtrlT fetchCtrl,
	output controlPkg::aluCtrlT aluCtrl,
	output controlPkg::vectorCtrlT vectorCtrl,
	output logic stop
);

	import controlPkg::*;

	instrClassT instrClass;
	stateT state;
	laneIndexT laneIndex;

	opcodeDecoder decoder0
	(
		.instr(instr),
		.instrClass(instrClass)
	);

	controlSequencer #(.numLanes(numLanes)) sequencer0
	(
		.clock(clock),
		.reset(reset),
		.instrClass(instrClass),
		.state(state),
		.laneIndex(laneIndex)
	);

	controlOutputs #(.numLanes(numLanes)) outputs0
	(
		.state(state),
		.instrClass(instrClass),
		.instr(instr),	// arith op select
		.laneIndex(laneIndex),
		.negative(negative),
		.zero(zero),
		.fetchCtrl(fetchCtrl),
		.aluCtrl(aluCtrl),
		.vectorCtrl(vectorCtrl),
		.stop(stop)
	);

endmodule

// File: testbench/controlUnitTb.sv
// ----------------------------------------
// control unit testbench
// replays instruction patterns and checks
// lengths, strobe counts and lane order
// ----------------------------------------

`timescale 1ns/1ps

module controlUnitTb;

	import controlPkg::*;

	localparam int numLanes = 4;
	localparam int fieldsPerLine = 11;
	localparam int maxPatterns = 64;
	localparam int resetCycles = 16;
	localparam int maxLength = 20;	// longer than any instruction

	logic clock;
	logic reset;
	instrT instr;
	logic negative;
	logic zero;
	fetchCtrlT fetchCtrl;
	aluCtrlT aluCtrl;
	vectorCtrlT vectorCtrl;
	logic stop;

	logic [7:0] patternMem [0:maxPatterns*fieldsPerLine-1];
	int patternCount;
	logic patternsLoaded;
	int errorCount;
	int checkCount;
	integer seed;

	controlUnit #(.numLanes(numLanes)) dut0
	(
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.negative(negative),
		.zero(zero),
		.fetchCtrl(fetchCtrl),
		.aluCtrl(aluCtrl),
		.vectorCtrl(vectorCtrl),
		.stop(stop)
	);

	always #20 clock = ~clock;	// 40 ns period

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	function automatic logic outputsActive();
		return (fetchCtrl != '0) || (aluCtrl != '0) || (vectorCtrl != '0) || stop;
	endfunction

	// opcodes 4, 6 and 8 are add, sub and nand
	function automatic aluOpT aluOpForInstr(input instrT code);
		if (code[3:0] == 4'h4)
			return aluAdd;
		else if (code[3:0] == 4'h6)
			return aluSub;
		else if (code[3:0] == 4'h8)
			return aluNand;
		else if (code[2:0] == 3'd3)
			return aluShift;
		else
			return aluOr;	// ori
	endfunction

	task automatic checkValue(input string what, input int got, input int expected);
		checkCount++;
		assert (got == expected)
		else
		begin
			errorCount++;
			$display("** Error at %0d ns: %s expected %0d, got %0d",
				$time, what, expected, got);
		end
	endtask

	// fixed bits from the file, the masked ones and flags of 2 from $random
	task automatic applyPattern(input int base);
		logic [7:0] mask;
		logic [31:0] r;
		mask = patternMem[base+1];
		r = $random(seed);
		instr = (patternMem[base] & ~mask) | (r[7:0] & mask);
		negative = (patternMem[base+2] == 8'd2) ? r[8] : patternMem[base+2][0];
		zero = (patternMem[base+3] == 8'd2) ? r[9] : patternMem[base+3][0];
	endtask

	// reset, one idle cycle, ends on the first fetch
	task automatic resetAndStart();
		reset = 1'b1;
		repeat (resetCycles)
		begin
			@(negedge clock);
			checkValue("outputs during reset", int'(outputsActive()), 0);
		end
		reset = 1'b0;
		checkValue("outputs in idle cycle", int'(outputsActive()), 0);
		@(negedge clock);
		checkValue("irLoad after idle cycle", int'(fetchCtrl.irLoad), 1);
	endtask

	// ----------------------------------------
	// one instruction, irLoad to next irLoad
	// ----------------------------------------

	task automatic runPattern(input int base);
		int cycles;
		int pcWrites;
		int rfWrites;
		int memReads;
		int memWrites;
		int vecWrites;
		int laneLoads;
		int laneStep;
		string tag;
		cycles = 0;
		pcWrites = 0;
		rfWrites = 0;
		memReads = 0;
		memWrites = 0;
		vecWrites = 0;
		laneLoads = 0;
		laneStep = 0;
		applyPattern(base);
		tag = $sformatf("instr %h n%0d z%0d", instr, negative, zero);
		do
		begin
			// mid-cycle values, fetch cycle first
			cycles++;
			pcWrites += int'(fetchCtrl.pcWrite);
			rfWrites += int'(aluCtrl.regFileWrite);
			memReads += int'(fetchCtrl.memRead);
			memWrites += int'(fetchCtrl.memWrite);
			vecWrites += int'(vectorCtrl.vectorWrite);
			laneLoads += $countones(vectorCtrl.laneLoad);
			if (aluCtrl.flagWrite)
				checkValue({tag, " aluOp"}, int'(aluCtrl.aluOp), int'(aluOpForInstr(instr)));
			// a lane cycle of vload or vstore
			if (vectorCtrl.laneLoad != '0 || (fetchCtrl.memWrite && vectorCtrl.r2Load))
			begin
				checkValue({tag, " laneSel"}, int'(vectorCtrl.laneSel), laneStep);
				if (vectorCtrl.laneLoad != '0)
					checkValue({tag, " laneLoad"}, int'(vectorCtrl.laneLoad), 1 << laneStep);
				laneStep++;
			end
			if (vectorCtrl.vectorWrite)
				checkValue({tag, " lanes before vectorWrite"}, laneStep, numLanes);
			@(negedge clock);
		end
		while (!fetchCtrl.irLoad && cycles < maxLength);
		checkValue({tag, " length"}, cycles, int'(patternMem[base+4]));
		checkValue({tag, " pcWrite"}, pcWrites, int'(patternMem[base+5]));
		checkValue({tag, " regFileWrite"}, rfWrites, int'(patternMem[base+6]));
		checkValue({tag, " memRead"}, memReads, int'(patternMem[base+7]));
		checkValue({tag, " memWrite"}, memWrites, int'(patternMem[base+8]));
		checkValue({tag, " vectorWrite"}, vecWrites, int'(patternMem[base+9]));
		checkValue({tag, " lane loads"}, laneLoads, int'(patternMem[base+10]));
	endtask

	// halt, stay halted ten cycles, then restart by reset
	task automatic runStop(input int base);
		int waitCycles;
		applyPattern(base);
		waitCycles = 0;
		while (!stop && waitCycles < maxLength)
		begin
			@(negedge clock);
			waitCycles++;
		end
		checkValue("stop raised", int'(stop), 1);
		repeat (10)
		begin
			@(negedge clock);
			checkValue("irLoad while halted", int'(fetchCtrl.irLoad), 0);
			checkValue("stop held", int'(stop), 1);
		end
		resetAndStart();
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		instr = '0;
		negative = 1'b0;
		zero = 1'b0;
		seed = 32'heb84;
		errorCount = 0;
		checkCount = 0;
		patternCount = 0;
		patternsLoaded = 1'b0;
		$readmemh("testbench/controlPatterns.txt", patternMem);
		while (patternCount < maxPatterns
			&& !(patternMem[patternCount*fieldsPerLine] == 8'hff
			&& patternMem[patternCount*fieldsPerLine+1] == 8'hff))
			patternCount++;
		if (patternCount == 0 || patternCount == maxPatterns)
		begin
			errorCount++;
			$display("The pattern file is missing, empty or has no end line.");
			patternCount = 0;
		end
		patternsLoaded = 1'b1;
		resetAndStart();
		for (int i = 0; i < patternCount; i++)
		begin
			if (patternMem[i*fieldsPerLine+4] == 8'd0)
				runStop(i * fieldsPerLine);
			else
				runPattern(i * fieldsPerLine);
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		wait (patternsLoaded);
		repeat (patternCount * 10 + 40) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles.", patternCount * 10 + 40);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: flist.f
logic/controlPkg.sv
logic/opcodeDecoder.sv
logic/controlSequencer.sv
logic/controlOutputs.sv
logic/controlUnit.sv
testbench/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# build the control unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controlUnitTb -f flist.f
output=$(./obj_dir/VcontrolUnitTb)
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
	exit 0
else
	exit 1
fi

// File: testbench/controlPatterns.txt
// instr mask negative zero length pcWrite regFileWrite memRead memWrite vectorWrite laneLoads
// mask bits of instr are random, a flag of 2 is random, length 0 halts, all ff ends the list
04 f0 2 2 4 1 1 1 0 0 0 // add
06 f0 2 2 4 1 1 1 0 0 0 // sub
08 f0 2 2 4 1 1 1 0 0 0 // nand
03 f8 2 2 4 1 1 1 0 0 0 // shift
07 f8 2 2 5 1 1 1 0 0 0 // ori
00 f0 2 2 4 1 1 2 0 0 0 // load
02 f0 2 2 3 1 0 1 1 0 0 // store
0d f0 0 0 3 2 0 1 0 0 0 // bpz
0d f0 0 1 3 2 0 1 0 0 0
0d f0 1 0 3 1 0 1 0 0 0
0d f0 1 1 3 1 0 1 0 0 0
05 f0 0 0 3 1 0 1 0 0 0 // bz
05 f0 0 1 3 2 0 1 0 0 0
05 f0 1 0 3 1 0 1 0 0 0
05 f0 1 1 3 2 0 1 0 0 0
09 f0 0 0 3 2 0 1 0 0 0 // bnz
09 f0 0 1 3 1 0 1 0 0 0
09 f0 1 0 3 2 0 1 0 0 0
09 f0 1 1 3 1 0 1 0 0 0
0a f0 2 2 7 1 0 5 0 1 4 // vload, four lanes
0c f0 2 2 6 1 0 1 4 0 0 // vstore, four lanes
81 00 2 2 3 1 0 1 0 0 0 // nop
0e f0 2 2 3 1 0 1 0 0 0 // illegal
11 00 2 2 3 1 0 1 0 0 0 // illegal
01 00 2 2 0 0 0 0 0 0 0 // stop, then reset
04 f0 2 2 4 1 1 1 0 0 0 // add after restart
0a f0 2 2 7 1 0 5 0 1 4 // vload after restart
ff ff ff ff ff ff ff ff ff ff ff
